// File: design/vec_pkg.sv
`default_nettype none

package vec_pkg;

    //////////////////////////////
    // fixed-point format
    //////////////////////////////

    // signed Q16.16, one 32-bit word
    localparam int FIX_W     = 32;
    localparam int FRAC_BITS = 16;

    // squared length needs the full product width
    localparam int LEN_W = 2 * FIX_W;

    typedef logic signed [FIX_W-1:0] fix_t;

    // unsigned Q32.32, sum of squares modulo 2^64
    typedef logic [LEN_W-1:0] len_sq_t;

    // 1.0 in Q16.16
    localparam fix_t FIX_ONE = fix_t'(1) <<< FRAC_BITS;

    //////////////////////////////
    // vectors and rays
    //////////////////////////////

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } vec3_t;

    // unnormalized direction plus its squared length for the divider
    typedef struct packed {
        vec3_t   dir;
        len_sq_t len_sq;
    } ray_t;

endpackage

`default_nettype wire

// File: design/screen_pkg.sv
`default_nettype none

package screen_pkg;

    //////////////////////////////
    // screen coordinates
    //////////////////////////////

    // column, 0 to 2047
    typedef logic [10:0] pix_x_t;

    // row, 0 to 1023
    typedef logic [9:0] pix_y_t;

    // one pixel as it arrives from the raster scan
    typedef struct packed {
        pix_x_t x;
        pix_y_t y;
    } pixel_t;

endpackage

`default_nettype wire

// File: design/pixel_axis_scale.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_axis_scale #(
    parameter vec_pkg::vec3_t BASIS = '0
) (
    input  logic           clk_in,
    input  logic           rst_n,

    input  logic           coord_valid,
    input  logic [10:0]    coord,

    output logic           scaled_valid,
    output vec_pkg::vec3_t scaled
);
    import vec_pkg::*;

    // stage 1 holds the widened coordinate
    logic  valid_s1;
    fix_t  coord_s1;

    // full-width products before the output register
    vec3_t prod;

    //////////////////////////////
    // valid chain
    //////////////////////////////

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1     <= 1'b0;
            scaled_valid <= 1'b0;
        end else begin
            valid_s1     <= coord_valid;
            scaled_valid <= valid_s1;
        end
    end

    //////////////////////////////
    // stage 1, capture coordinate
    //////////////////////////////

    // coordinate is a plain integer, so zero-extend it to a word
    always_ff @(posedge clk_in) begin
        if (coord_valid) begin
            coord_s1 <= fix_t'({{(FIX_W - $bits(coord)){1'b0}}, coord});
        end
    end

    //////////////////////////////
    // stage 2, scale basis
    //////////////////////////////

    // integer times Q16.16 is already Q16.16, keep the low word
    always_comb begin
        prod.x = coord_s1 * BASIS.x;
        prod.y = coord_s1 * BASIS.y;
        prod.z = coord_s1 * BASIS.z;
    end

    always_ff @(posedge clk_in) begin
        if (valid_s1) begin
            scaled <= prod;
        end
    end

endmodule

`default_nettype wire

// File: design/ray_dir_combine.sv
`timescale 1ns/10ps
`default_nettype none

module ray_dir_combine #(
    parameter int EYE_X   = 0,
    parameter int EYE_Y   = 0,
    parameter int EYE_Z   = 0,
    parameter int PLANE_Z = 0,
    parameter int HALF_W  = 0,
    parameter int HALF_H  = 0
) (
    input  logic           clk_in,
    input  logic           rst_n,

    // both scalers run in lockstep, u_valid drives the pipeline
    input  logic           u_valid,
    input  vec_pkg::vec3_t u_scaled,
    input  logic           v_valid,
    input  vec_pkg::vec3_t v_scaled,

    output logic           ray_valid,
    output vec_pkg::ray_t  ray
);
    import vec_pkg::*;

    //////////////////////////////
    // camera constants
    //////////////////////////////

    // top-left corner of the projection plane, whole units
    localparam int CORNER_X = EYE_X - HALF_W;
    localparam int CORNER_Y = EYE_Y - HALF_H;
    localparam int CORNER_Z = PLANE_Z;

    // corner minus eye, folded into one constant vector
    localparam vec3_t OFFSET = '{
        x: fix_t'((CORNER_X - EYE_X) <<< FRAC_BITS),
        y: fix_t'((CORNER_Y - EYE_Y) <<< FRAC_BITS),
        z: fix_t'((CORNER_Z - EYE_Z) <<< FRAC_BITS)
    };

    // per-component squares
    typedef struct packed {
        len_sq_t x;
        len_sq_t y;
        len_sq_t z;
    } sq3_t;

    // signed square in full width, modulo 2^64
    function automatic len_sq_t square(input fix_t a);
        logic signed [LEN_W-1:0] wide;
        wide = LEN_W'(a);
        return len_sq_t'(wide * wide);
    endfunction

    logic  valid_s1;
    logic  valid_s2;
    vec3_t dir_s1;
    vec3_t dir_s2;
    sq3_t  sq_s2;

    //////////////////////////////
    // valid chain
    //////////////////////////////

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            ray_valid <= 1'b0;
        end else begin
            valid_s1  <= u_valid;
            valid_s2  <= valid_s1;
            ray_valid <= valid_s2;
        end
    end

    //////////////////////////////
    // stage 1, direction
    //////////////////////////////

    // plane point minus eye, all sums wrap at 32 bits
    always_ff @(posedge clk_in) begin
        if (u_valid) begin
            dir_s1.x <= u_scaled.x + v_scaled.x + OFFSET.x;
            dir_s1.y <= u_scaled.y + v_scaled.y + OFFSET.y;
            dir_s1.z <= u_scaled.z + v_scaled.z + OFFSET.z;
        end
    end

    //////////////////////////////
    // stage 2, squares
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (valid_s1) begin
            sq_s2.x <= square(dir_s1.x);
            sq_s2.y <= square(dir_s1.y);
            sq_s2.z <= square(dir_s1.z);
            dir_s2  <= dir_s1;
        end
    end

    //////////////////////////////
    // stage 3, sum of squares
    //////////////////////////////

    // dir rides along so both halves of the ray leave together
    always_ff @(posedge clk_in) begin
        if (valid_s2) begin
            ray.len_sq <= sq_s2.x + sq_s2.y + sq_s2.z;
            ray.dir    <= dir_s2;
        end
    end

endmodule

`default_nettype wire

// File: design/ray_gen_top.sv
`timescale 1ns/10ps
`default_nettype none

module ray_gen_top #(
    // camera basis in Q16.16
    parameter vec_pkg::vec3_t U_BASIS = '{x: vec_pkg::FIX_ONE, y: '0, z: '0},
    parameter vec_pkg::vec3_t V_BASIS = '{x: '0, y: vec_pkg::FIX_ONE, z: '0},

    // eye and plane geometry in whole units
    parameter int EYE_X   = 1800,
    parameter int EYE_Y   = 1800,
    parameter int EYE_Z   = -300,
    parameter int PLANE_Z = 100,
    parameter int HALF_W  = 256,
    parameter int HALF_H  = 192
) (
    input  logic               clk_in,
    input  logic               rst_n,

    input  logic               pixel_valid,
    input  screen_pkg::pixel_t pixel,

    output logic               ray_valid,
    output vec_pkg::ray_t      ray
);
    import vec_pkg::*;
    import screen_pkg::*;

    logic   u_valid;
    vec3_t  u_scaled;
    logic   v_valid;
    vec3_t  v_scaled;

    // row widened to the column width so both axes share one scaler
    pix_x_t row_ext;

    assign row_ext = pix_x_t'(pixel.y);

    //////////////////////////////
    // axis scalers
    //////////////////////////////

    pixel_axis_scale #(
        .BASIS(U_BASIS)
    ) scale_u (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .coord_valid (pixel_valid),
        .coord       (pixel.x),
        .scaled_valid(u_valid),
        .scaled      (u_scaled)
    );

    pixel_axis_scale #(
        .BASIS(V_BASIS)
    ) scale_v (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .coord_valid (pixel_valid),
        .coord       (row_ext),
        .scaled_valid(v_valid),
        .scaled      (v_scaled)
    );

    //////////////////////////////
    // direction and length
    //////////////////////////////

    ray_dir_combine #(
        .EYE_X  (EYE_X),
        .EYE_Y  (EYE_Y),
        .EYE_Z  (EYE_Z),
        .PLANE_Z(PLANE_Z),
        .HALF_W (HALF_W),
        .HALF_H (HALF_H)
    ) combine (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .u_valid  (u_valid),
        .u_scaled (u_scaled),
        .v_valid  (v_valid),
        .v_scaled (v_scaled),
        .ray_valid(ray_valid),
        .ray      (ray)
    );

endmodule

`default_nettype wire

// File: dv/ray_gen_chk.sv
`timescale 1ns/10ps
`default_nettype none

module ray_gen_chk (
    input logic          clk_in,
    input logic          rst_n,
    input logic          u_valid,
    input logic          v_valid,
    input logic          ray_valid,
    input vec_pkg::ray_t ray
);

    //////////////////////////////
    // combiner alignment
    //////////////////////////////

    // both scalers see the same strobe, so they stay in lockstep
    a_lockstep: assert property (@(posedge clk_in) disable iff (!rst_n)
        u_valid == v_valid)
        else $error("u_valid and v_valid disagree");

    // three register stages from u_valid to ray_valid
    a_latency: assert property (@(posedge clk_in) disable iff (!rst_n)
        ray_valid == $past(u_valid, 3))
        else $error("ray_valid does not follow u_valid by three cycles");

    a_known: assert property (@(posedge clk_in) disable iff (!rst_n)
        ray_valid |-> !$isunknown(ray))
        else $error("ray has unknown bits while ray_valid is high");

endmodule

bind ray_dir_combine ray_gen_chk chk0 (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .u_valid  (u_valid),
    .v_valid  (v_valid),
    .ray_valid(ray_valid),
    .ray      (ray)
);

`default_nettype wire

// File: dv/ray_gen_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ray_gen_tb;
    import vec_pkg::*;
    import screen_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 10;
    localparam int IDLE_CYCLES    = 20;
    localparam int NUM_PIXELS     = 200;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int PIPE_LATENCY   = 5;

    // tilted camera, far plane so dir.z wraps for large pixels
    localparam int EYE_X   = 700;
    localparam int EYE_Y   = 500;
    localparam int EYE_Z   = -20000;
    localparam int PLANE_Z = 12000;
    localparam int HALF_W  = 1024;
    localparam int HALF_H  = 512;

    // u = (1, 0, 0.5), v = (0, 1, -0.25)
    localparam vec3_t U_BASIS = '{x: fix_t'(32'h0001_0000), y: fix_t'(32'h0),
                                  z: fix_t'(32'h0000_8000)};
    localparam vec3_t V_BASIS = '{x: fix_t'(32'h0), y: fix_t'(32'h0001_0000),
                                  z: fix_t'(32'hFFFF_C000)};

    logic   clk_in;
    logic   rst_n;
    logic   pixel_valid;
    pixel_t pixel;
    logic   ray_valid;
    ray_t   ray;

    ray_t exp_q[$];
    int   exp_edge_q[$];
    int   edge_count     = 0;
    int   error_count    = 0;
    int   latency_errors = 0;
    int   rays_seen      = 0;
    int   pixels_sent    = 0;
    int   tests_run      = 0;
    int   tests_failed   = 0;
    int   seed           = 60;
    bit   timed_out      = 1'b0;

    ray_gen_top #(
        .U_BASIS(U_BASIS),
        .V_BASIS(V_BASIS),
        .EYE_X  (EYE_X),
        .EYE_Y  (EYE_Y),
        .EYE_Z  (EYE_Z),
        .PLANE_Z(PLANE_Z),
        .HALF_W (HALF_W),
        .HALF_H (HALF_H)
    ) dut0 (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .pixel_valid(pixel_valid),
        .pixel      (pixel),
        .ray_valid  (ray_valid),
        .ray        (ray)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    always @(posedge clk_in) edge_count <= edge_count + 1;

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic vec3_t scale_axis(input int coord, input vec3_t basis);
        vec3_t s;
        s.x = fix_t'(longint'(coord) * longint'(basis.x));
        s.y = fix_t'(longint'(coord) * longint'(basis.y));
        s.z = fix_t'(longint'(coord) * longint'(basis.z));
        return s;
    endfunction

    function automatic ray_t model_ray(input pixel_t p);
        vec3_t  su;
        vec3_t  sv;
        vec3_t  offs;
        ray_t   r;
        longint sq_x;
        longint sq_y;
        longint sq_z;
        su = scale_axis(int'(p.x), U_BASIS);
        sv = scale_axis(int'(p.y), V_BASIS);
        // plane corner minus eye, whole units to Q16.16
        offs.x = fix_t'(((EYE_X - HALF_W) - EYE_X) * (1 << FRAC_BITS));
        offs.y = fix_t'(((EYE_Y - HALF_H) - EYE_Y) * (1 << FRAC_BITS));
        offs.z = fix_t'((PLANE_Z - EYE_Z) * (1 << FRAC_BITS));
        r.dir.x = su.x + sv.x + offs.x;
        r.dir.y = su.y + sv.y + offs.y;
        r.dir.z = su.z + sv.z + offs.z;
        sq_x = longint'(r.dir.x) * longint'(r.dir.x);
        sq_y = longint'(r.dir.y) * longint'(r.dir.y);
        sq_z = longint'(r.dir.z) * longint'(r.dir.z);
        r.len_sq = len_sq_t'(sq_x) + len_sq_t'(sq_y) + len_sq_t'(sq_z);
        return r;
    endfunction

    function automatic pixel_t random_pixel();
        logic [31:0] r;
        pixel_t      p;
        r = $random(seed);
        p.x = r[10:0];
        p.y = r[20:11];
        return p;
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_dir(input vec3_t exp_dir, input vec3_t act_dir);
        if (act_dir !== exp_dir) begin
            $display("FAIL ray.dir expected %h actual %h", exp_dir, act_dir);
            error_count++;
        end
    endtask

    task automatic check_len(input len_sq_t exp_len, input len_sq_t act_len);
        if (act_len !== exp_len) begin
            $display("FAIL ray.len_sq expected %h actual %h", exp_len, act_len);
            error_count++;
        end
    endtask

    task automatic check_latency(input int exp_edge, input int act_edge);
        if (act_edge != exp_edge) begin
            $display("FAIL ray_valid edge expected %h actual %h", exp_edge, act_edge);
            error_count++;
            latency_errors++;
        end
    endtask

    // rays are taken at the falling edge where they are stable
    always @(negedge clk_in) begin : monitor
        ray_t exp_ray;
        int   exp_edge;
        if (!rst_n) begin
            if (ray_valid !== 1'b0) begin
                $display("ray_valid was not low during reset");
                error_count++;
            end
        end else if (ray_valid === 1'b1) begin
            rays_seen++;
            if (exp_q.size() == 0) begin
                $display("ray_valid came high with no pixel waiting for it");
                error_count++;
            end else begin
                exp_ray  = exp_q.pop_front();
                exp_edge = exp_edge_q.pop_front();
                check_dir(exp_ray.dir, ray.dir);
                check_len(exp_ray.len_sq, ray.len_sq);
                // the next rising edge is the one that samples this ray
                check_latency(exp_edge, edge_count + 1);
            end
        end
    end

    //////////////////////////////
    // drivers
    //////////////////////////////

    task automatic drive_pixel(input pixel_t p);
        @(posedge clk_in);
        #(DRIVE_DELAY);
        pixel_valid = 1'b1;
        pixel       = p;
        exp_q.push_back(model_ray(p));
        exp_edge_q.push_back(edge_count + 1 + PIPE_LATENCY);
        pixels_sent++;
    endtask

    task automatic drive_idle();
        @(posedge clk_in);
        #(DRIVE_DELAY);
        pixel_valid = 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s, %0d rays never came out", what, exp_q.size());
            error_count++;
            timed_out = 1'b1;
        end else begin
            // idle a little longer so stray rays show up here
            repeat (PIPE_LATENCY + 2) @(posedge clk_in);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d mismatches", num, name, errs);
            tests_failed++;
        end
    endtask

    task automatic check_count(input int rays_before, input int pixels_before);
        if (rays_seen - rays_before != pixels_sent - pixels_before) begin
            $display("%0d rays came out for %0d pixels", rays_seen - rays_before,
                     pixels_sent - pixels_before);
            error_count++;
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic run_stream(input int num, input string name, input bit sparse);
        int errs_before;
        int rays_before;
        int pixels_before;
        int sent;
        int cycles;
        errs_before   = error_count;
        rays_before   = rays_seen;
        pixels_before = pixels_sent;
        sent          = 0;
        cycles        = 0;
        while (sent < NUM_PIXELS && cycles < TIMEOUT_CYCLES) begin
            if (sparse && ($random(seed) & 1) == 0) begin
                drive_idle();
            end else begin
                drive_pixel(random_pixel());
                sent++;
            end
            cycles++;
        end
        drive_idle();
        if (sent < NUM_PIXELS) begin
            $display("timeout in %s, only %0d pixels were sent", name, sent);
            error_count++;
            timed_out = 1'b1;
        end else begin
            wait_drain(name);
        end
        check_count(rays_before, pixels_before);
        report_test(num, name, error_count - errs_before);
    endtask

    initial begin
        int     errs_before;
        pixel_t p;
        clk_in      = 1'b0;
        rst_n       = 1'b0;
        pixel_valid = 1'b0;
        pixel       = '0;

        // 1, quiet through reset and idle
        errs_before = error_count;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk_in);
        report_test(1, "reset quiet", error_count - errs_before);

        // 2, the four screen corners one at a time
        errs_before = error_count;
        for (int i = 0; i < 4 && !timed_out; i++) begin
            p.x = (i & 1) ? pix_x_t'(2047) : pix_x_t'(0);
            p.y = (i & 2) ? pix_y_t'(1023) : pix_y_t'(0);
            drive_pixel(p);
            drive_idle();
            wait_drain("corner pixels");
        end
        report_test(2, "corner pixels", error_count - errs_before);

        if (!timed_out) run_stream(3, "dense random stream", 1'b0);
        if (!timed_out) run_stream(4, "sparse random stream", 1'b1);
        report_test(5, "fixed latency", latency_errors);

        // 6, far corner so dir.z wraps and len_sq is near the top
        if (!timed_out) begin
            errs_before = error_count;
            for (int i = 0; i < 8; i++) begin
                p.x = pix_x_t'(2047 - i);
                p.y = pix_y_t'(1023 - 3 * i);
                drive_pixel(p);
            end
            drive_idle();
            wait_drain("squared-length wrap");
            report_test(6, "squared-length wrap", error_count - errs_before);
        end

        $display("tests %0d, failed %0d, pixels %0d, rays %0d, errors %0d",
                 tests_run, tests_failed, pixels_sent, rays_seen, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
// packages first, then RTL bottom up, then testbench
design/vec_pkg.sv
design/screen_pkg.sv
design/pixel_axis_scale.sv
design/ray_dir_combine.sv
design/ray_gen_top.sv
dv/ray_gen_chk.sv
dv/ray_gen_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ray generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=ray_gen_tb
BUILD_DIR=obj_dir
SIM=ray_gen_sim
LOG=run.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$SIM" \
    -f sources.f
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    echo "result: fail"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
